// ==== src/rv_decode_pkg.sv ====
package rv_decode_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32I major opcodes.
  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_jal      = 7'b1101111;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system   = 7'b1110011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // ------------------------------------------------------------
  // Stage payloads
  // ------------------------------------------------------------
  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    xlen_t    imm;
    alu_op_t  alu_op;
    xlen_t    op1;
    xlen_t    op2;
    reg_idx_t rd;
    logic     wen;
    logic     load;
    logic     store;
    logic     jump;
    logic     branch;
    logic     ecall;
    logic     ebreak;
    logic     mret;
    logic     csr;
    logic     illegal;
  } decode_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xlen_t    data;
  } exu_fwd_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    xlen_t    data;
  } wb_t;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
  import rv_decode_pkg::*;
#(
  parameter int num_regs = 32
) (
  input  logic     clock,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  output xlen_t    rdata1,
  output xlen_t    rdata2,
  input  wb_t      wb
);

  localparam int idx_w = $clog2(num_regs);

  xlen_t regs [num_regs];

  // Only the low bits select a register (RV32E keeps 16).
  logic [idx_w-1:0] waddr;
  logic [idx_w-1:0] rsel1;
  logic [idx_w-1:0] rsel2;

  assign waddr = wb.rd[idx_w-1:0];
  assign rsel1 = raddr1[idx_w-1:0];
  assign rsel2 = raddr2[idx_w-1:0];

  // Write port. x0 is hardwired.
  always_ff @(posedge clock) begin
    if (wb.valid && waddr != '0) begin
      regs[waddr] <= wb.data;
    end
  end

  // Read ports see the old value during a write cycle.
  assign rdata1 = (rsel1 == '0) ? '0 : regs[rsel1];
  assign rdata2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// ==== src/rv_scoreboard.sv ====
`timescale 1ns/1ps

module rv_scoreboard
  import rv_decode_pkg::*;
#(
  parameter int num_regs = 32
) (
  input  logic     clock,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output logic     busy1,
  output logic     busy2,
  input  logic     issue,
  input  reg_idx_t issue_rd,
  input  logic     wb_valid,
  input  reg_idx_t wb_rd
);

  localparam int idx_w = $clog2(num_regs);

  // One pending-write bit per register.
  logic [num_regs-1:0] busy;

  logic [idx_w-1:0] set_idx;
  logic [idx_w-1:0] clr_idx;
  logic             set_en;

  assign set_idx = issue_rd[idx_w-1:0];
  assign clr_idx = wb_rd[idx_w-1:0];
  assign set_en  = issue && (set_idx != '0);

  // ------------------------------------------------------------
  // Set and clear
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb_valid) begin
        busy[clr_idx] <= 1'b0;
      end
      // Later assignment wins, so a same-edge issue keeps the bit set.
      if (set_en) begin
        busy[set_idx] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Operand lookup
  // ------------------------------------------------------------
  assign busy1 = busy[rs1[idx_w-1:0]];
  assign busy2 = busy[rs2[idx_w-1:0]];

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder
  import rv_decode_pkg::*;
(
  input  inst_t   inst,
  input  xlen_t   pc,
  input  xlen_t   rs1_val,
  input  xlen_t   rs2_val,
  output decode_t dec,
  output logic    uses_rs1,
  output logic    uses_rs2
);

  function automatic alu_op_t alu_from_funct3(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    case (funct3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_ok;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // Only add/sub and srl/sra have an alternate encoding.
  assign alt_ok = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  // ------------------------------------------------------------
  // Immediates
  // ------------------------------------------------------------
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ------------------------------------------------------------
  // Main decode
  // ------------------------------------------------------------
  always_comb begin
    dec      = '0;
    dec.pc   = pc;
    dec.inst = inst;
    dec.alu_op = alu_add;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;

    case (opcode)
      opc_lui: begin
        dec.imm    = imm_u;
        dec.alu_op = alu_pass_b;
        dec.wen    = 1'b1;
      end
      opc_auipc: begin
        dec.imm = imm_u;
        dec.op1 = pc;
        dec.wen = 1'b1;
      end
      opc_jal: begin
        dec.imm  = imm_j;
        dec.op1  = pc;
        dec.jump = 1'b1;
        dec.wen  = 1'b1;
      end
      opc_jalr: begin
        dec.imm  = imm_i;
        dec.jump = 1'b1;
        dec.wen  = 1'b1;
        uses_rs1 = 1'b1;
      end
      opc_branch: begin
        dec.imm  = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3[2:1])
          2'b00:   dec.alu_op = alu_sub;
          2'b10:   dec.alu_op = alu_slt;
          2'b11:   dec.alu_op = alu_sltu;
          default: dec.illegal = 1'b1;
        endcase
        dec.branch = !dec.illegal;
      end
      opc_load: begin
        dec.imm  = imm_i;
        dec.load = 1'b1;
        dec.wen  = 1'b1;
        uses_rs1 = 1'b1;
      end
      opc_store: begin
        dec.imm   = imm_s;
        dec.store = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
      end
      opc_op_imm: begin
        dec.imm    = imm_i;
        dec.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && inst[30]);
        dec.wen    = 1'b1;
        uses_rs1   = 1'b1;
      end
      opc_op: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        if (alt_ok) begin
          dec.alu_op = alu_from_funct3(funct3, inst[30]);
          dec.wen    = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      opc_misc_mem: begin
        // Fence and fence.i retire as no-ops.
      end
      opc_system: begin
        if (funct3 == 3'b000) begin
          case (inst[31:20])
            12'h000: dec.ecall  = 1'b1;
            12'h001: dec.ebreak = 1'b1;
            12'h302: dec.mret   = 1'b1;
            default: dec.illegal = 1'b1;
          endcase
        end else if (funct3 != 3'b100) begin
          // CSR address travels in imm, zimm in op1.
          dec.imm  = {20'b0, inst[31:20]};
          dec.csr  = 1'b1;
          dec.wen  = 1'b1;
          uses_rs1 = !funct3[2];
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // Operand selection.
    if (uses_rs1) begin
      dec.op1 = rs1_val;
    end
    if (dec.csr && funct3[2]) begin
      dec.op1 = {27'b0, inst[19:15]};
    end
    dec.op2 = (opcode == opc_op || opcode == opc_branch) ? rs2_val : dec.imm;
    dec.rd  = dec.wen ? inst[11:7] : '0;
  end

endmodule

// ==== src/rv_idu.sv ====
`timescale 1ns/1ps

module rv_idu
  import rv_decode_pkg::*;
(
  input  logic     clock,
  input  logic     reset,

  input  logic     in_valid,
  input  inst_t    in_inst,
  input  xlen_t    in_pc,
  output logic     in_ready,

  output reg_idx_t rs1,
  output reg_idx_t rs2,
  input  xlen_t    rdata1,
  input  xlen_t    rdata2,
  input  logic     busy1,
  input  logic     busy2,

  input  exu_fwd_t exu_fwd,

  output logic     issue,
  output reg_idx_t issue_rd,

  output logic     out_valid,
  output decode_t  out_dec,
  input  logic     out_ready
);

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------
  logic  valid;
  inst_t inst_q;
  xlen_t pc_q;

  logic  fire_in;
  logic  fire_out;
  logic  hazard;
  logic  uses_rs1;
  logic  uses_rs2;
  logic  fwd1;
  logic  fwd2;
  xlen_t rs1_val;
  xlen_t rs2_val;

  assign fire_in  = in_valid && in_ready;
  assign fire_out = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (fire_in) begin
      valid <= 1'b1;
    end else if (fire_out) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (fire_in) begin
      inst_q <= in_inst;
      pc_q   <= in_pc;
    end
  end

  assign rs1 = inst_q[19:15];
  assign rs2 = inst_q[24:20];

  // ------------------------------------------------------------
  // Hazard and handshake
  // ------------------------------------------------------------
  assign hazard = valid &&
                  ((uses_rs1 && rs1 != '0 && busy1) ||
                   (uses_rs2 && rs2 != '0 && busy2));

  assign out_valid = valid && !hazard;
  // Stage empty, or draining on this edge.
  assign in_ready  = !valid || fire_out;

  assign issue    = fire_out && out_dec.wen && out_dec.rd != '0;
  assign issue_rd = out_dec.rd;

  // Execute result bypass.
  assign fwd1    = exu_fwd.valid && exu_fwd.rd != '0 && exu_fwd.rd == rs1;
  assign fwd2    = exu_fwd.valid && exu_fwd.rd != '0 && exu_fwd.rd == rs2;
  assign rs1_val = fwd1 ? exu_fwd.data : rdata1;
  assign rs2_val = fwd2 ? exu_fwd.data : rdata2;

  rv_decoder u_rv_decoder (
    .inst     (inst_q),
    .pc       (pc_q),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .dec      (out_dec),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2)
  );

endmodule

// ==== src/rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top
  import rv_decode_pkg::*;
#(
  parameter int num_regs = 32
) (
  input  logic     clock,
  input  logic     reset,

  input  logic     in_valid,
  input  inst_t    in_inst,
  input  xlen_t    in_pc,
  output logic     in_ready,

  output logic     out_valid,
  output decode_t  out_dec,
  input  logic     out_ready,

  input  exu_fwd_t exu_fwd,
  input  wb_t      wb
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  xlen_t    rdata1;
  xlen_t    rdata2;
  logic     busy1;
  logic     busy2;
  logic     issue;
  reg_idx_t issue_rd;

  rv_regfile #(
    .num_regs (num_regs)
  ) u_rv_regfile (
    .clock  (clock),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

  rv_scoreboard #(
    .num_regs (num_regs)
  ) u_rv_scoreboard (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .busy1    (busy1),
    .busy2    (busy2),
    .issue    (issue),
    .issue_rd (issue_rd),
    .wb_valid (wb.valid),
    .wb_rd    (wb.rd)
  );

  rv_idu u_rv_idu (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .in_pc     (in_pc),
    .in_ready  (in_ready),
    .rs1       (rs1),
    .rs2       (rs2),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .busy1     (busy1),
    .busy2     (busy2),
    .exu_fwd   (exu_fwd),
    .issue     (issue),
    .issue_rd  (issue_rd),
    .out_valid (out_valid),
    .out_dec   (out_dec),
    .out_ready (out_ready)
  );

endmodule

// ==== dv/rv_decode_props.sv ====
`timescale 1ns/1ps

module rv_decode_props
  import rv_decode_pkg::*;
(
  input logic    clock,
  input logic    reset,
  input logic    out_valid,
  input logic    out_ready,
  input decode_t out_dec,
  input logic    in_ready,
  input logic    hazard,
  input logic    busy_x0
);

  // Held output may not change under back-pressure.
  assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_dec))
    else $error("out_dec changed while held");

  assert property (@(posedge clock) reset |=> !out_valid)
    else $error("out_valid high right after reset");

  assert property (@(posedge clock) disable iff (reset) hazard |-> !in_ready)
    else $error("in_ready high during a stall");

  assert property (@(posedge clock) disable iff (reset) !busy_x0)
    else $error("x0 marked busy");

endmodule

bind rv_idu rv_decode_props u_idu_props (
  .clock     (clock),
  .reset     (reset),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_dec   (out_dec),
  .in_ready  (in_ready),
  .hazard    (hazard),
  .busy_x0   (1'b0)
);

bind rv_scoreboard rv_decode_props u_sb_props (
  .clock     (clock),
  .reset     (reset),
  .out_valid (1'b0),
  .out_ready (1'b0),
  .out_dec   ('0),
  .in_ready  (1'b0),
  .hazard    (1'b0),
  .busy_x0   (busy[0])
);

// ==== dv/rv_decode_tb.sv ====
`timescale 1ns/1ps

module rv_decode_tb
  import rv_decode_pkg::*;
;

  // Flags from bit 9 down are wen load store jump branch ecall ebreak mret csr illegal.
  localparam logic [9:0] f_wen = 10'b10_0000_0000;
  localparam logic [9:0] f_load = 10'b01_0000_0000;
  localparam logic [9:0] f_store = 10'b00_1000_0000;
  localparam logic [9:0] f_jump = 10'b00_0100_0000;
  localparam logic [9:0] f_branch = 10'b00_0010_0000;
  localparam logic [9:0] f_ecall = 10'b00_0001_0000;
  localparam logic [9:0] f_ebreak = 10'b00_0000_1000;
  localparam logic [9:0] f_mret = 10'b00_0000_0100;
  localparam logic [9:0] f_csr = 10'b00_0000_0010;
  localparam logic [9:0] f_illegal = 10'b00_0000_0001;

  typedef struct {
    inst_t    inst;
    xlen_t    pc;
    exu_fwd_t fwd;
    int       wb_at;
    wb_t      rel;
    alu_op_t  alu;
    xlen_t    imm;
    xlen_t    op1;
    xlen_t    op2;
    reg_idx_t rd;
    logic [9:0] flags;
  } row_t;

  logic     clock;
  logic     reset;
  logic     in_valid;
  inst_t    in_inst;
  xlen_t    in_pc;
  logic     in_ready;
  logic     out_valid;
  decode_t  out_dec;
  logic     out_ready;
  exu_fwd_t exu_fwd;
  wb_t      wb;

  row_t rows[$];
  logic table_ready;

  rv_decode_top #(
    .num_regs (32)
  ) u_rv_decode_top (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .in_pc     (in_pc),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_dec   (out_dec),
    .out_ready (out_ready),
    .exu_fwd   (exu_fwd),
    .wb        (wb)
  );

  always #10 clock = ~clock;

  // ------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ------------------------------------------------------------
  // RV32I encoders
  // ------------------------------------------------------------
  function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic xlen_t preload_value(input int idx);
    return 32'hA500_0000 + 32'(idx) * 32'h0000_0101;
  endfunction

  function automatic xlen_t next_pc();
    return 32'h0000_1000 + 32'(rows.size()) * 32'd4;
  endfunction

  function automatic exu_fwd_t make_fwd(input logic valid, input reg_idx_t rd, input xlen_t data);
    exu_fwd_t f;
    f.valid = valid;
    f.rd    = rd;
    f.data  = data;
    return f;
  endfunction

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  task automatic add_row(input inst_t inst, input exu_fwd_t fwd, input int wb_at,
                         input xlen_t wb_data, input alu_op_t alu, input xlen_t imm,
                         input xlen_t op1, input xlen_t op2, input reg_idx_t rd,
                         input logic [9:0] flags);
    row_t r;
    r.inst      = inst;
    r.pc        = next_pc();
    r.fwd       = fwd;
    r.wb_at     = wb_at;
    r.rel.valid = 1'b1;
    r.rel.rd    = 5'd8;
    r.rel.data  = wb_data;
    r.alu       = alu;
    r.imm       = imm;
    r.op1       = op1;
    r.op2       = op2;
    r.rd        = rd;
    r.flags     = flags;
    rows.push_back(r);
  endtask

  task automatic build_table();
    exu_fwd_t nf;
    nf = '0;
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10), nf, -1, '0, alu_add, '0,
            preload_value(1), preload_value(2), 5'd10, f_wen);
    add_row(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd11), nf, -1, '0, alu_sub, '0,
            preload_value(3), preload_value(4), 5'd11, f_wen);
    add_row(enc_r(7'h20, 5'd6, 5'd5, 3'd5, 5'd12), nf, -1, '0, alu_sra, '0,
            preload_value(5), preload_value(6), 5'd12, f_wen);
    add_row(enc_r(7'h00, 5'd1, 5'd7, 3'd3, 5'd13), nf, -1, '0, alu_sltu, '0,
            preload_value(7), preload_value(1), 5'd13, f_wen);
    add_row(enc_i(12'hFFB, 5'd2, 3'd0, 5'd14, 7'b0010011), nf, -1, '0, alu_add,
            32'hFFFF_FFFB, preload_value(2), 32'hFFFF_FFFB, 5'd14, f_wen);
    add_row(enc_i(12'h407, 5'd3, 3'd5, 5'd15, 7'b0010011), nf, -1, '0, alu_sra,
            32'h0000_0407, preload_value(3), 32'h0000_0407, 5'd15, f_wen);
    add_row(enc_i(12'h7F0, 5'd4, 3'd7, 5'd16, 7'b0010011), nf, -1, '0, alu_and,
            32'h0000_07F0, preload_value(4), 32'h0000_07F0, 5'd16, f_wen);
    add_row(enc_u(20'hABCDE, 5'd17, 7'b0110111), nf, -1, '0, alu_pass_b,
            32'hABCD_E000, '0, 32'hABCD_E000, 5'd17, f_wen);
    add_row(enc_u(20'h12345, 5'd18, 7'b0010111), nf, -1, '0, alu_add,
            32'h1234_5000, next_pc(), 32'h1234_5000, 5'd18, f_wen);
    add_row(enc_j(21'h000800, 5'd19), nf, -1, '0, alu_add,
            32'h0000_0800, next_pc(), 32'h0000_0800, 5'd19, f_wen | f_jump);
    add_row(enc_i(12'hFF0, 5'd5, 3'd0, 5'd20, 7'b1100111), nf, -1, '0, alu_add,
            32'hFFFF_FFF0, preload_value(5), 32'hFFFF_FFF0, 5'd20, f_wen | f_jump);
    // bge with a negative offset.
    add_row(enc_b(13'h1FF8, 5'd2, 5'd1, 3'd5), nf, -1, '0, alu_slt,
            32'hFFFF_FFF8, preload_value(1), preload_value(2), 5'd0, f_branch);
    add_row(enc_i(12'h00C, 5'd6, 3'd2, 5'd21, 7'b0000011), nf, -1, '0, alu_add,
            32'h0000_000C, preload_value(6), 32'h0000_000C, 5'd21, f_wen | f_load);
    add_row(enc_s(12'hFFC, 5'd7, 5'd2, 3'd2), nf, -1, '0, alu_add,
            32'hFFFF_FFFC, preload_value(2), 32'hFFFF_FFFC, 5'd0, f_store);
    add_row(32'h0000_0073, nf, -1, '0, alu_add, '0, '0, '0, 5'd0, f_ecall);
    add_row(32'h0010_0073, nf, -1, '0, alu_add, '0, '0, '0, 5'd0, f_ebreak);
    add_row(32'h3020_0073, nf, -1, '0, alu_add, '0, '0, '0, 5'd0, f_mret);
    add_row(enc_i(12'h300, 5'd3, 3'd1, 5'd22, 7'b1110011), nf, -1, '0, alu_add,
            32'h0000_0300, preload_value(3), 32'h0000_0300, 5'd22, f_wen | f_csr);
    add_row(enc_i(12'h341, 5'd5, 3'd6, 5'd23, 7'b1110011), nf, -1, '0, alu_add,
            32'h0000_0341, 32'd5, 32'h0000_0341, 5'd23, f_wen | f_csr);
    add_row(32'hFFFF_FFFF, nf, -1, '0, alu_add, '0, '0, '0, 5'd0, f_illegal);
    // Forwarding from execute, then a forward aimed at x0.
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd24), make_fwd(1'b1, 5'd1, 32'hDEAD_BEEF), -1,
            '0, alu_add, '0, 32'hDEAD_BEEF, preload_value(2), 5'd24, f_wen);
    add_row(enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd25), make_fwd(1'b1, 5'd0, 32'h0000_0055), -1,
            '0, alu_add, '0, '0, preload_value(3), 5'd25, f_wen);
    // x8 goes busy, lui and jal pass, then a reader waits for writeback.
    add_row(enc_i(12'h055, 5'd0, 3'd0, 5'd8, 7'b0010011), nf, -1, '0, alu_add,
            32'h0000_0055, '0, 32'h0000_0055, 5'd8, f_wen);
    add_row(enc_u(20'h00040, 5'd26, 7'b0110111), nf, -1, '0, alu_pass_b,
            32'h0004_0000, '0, 32'h0004_0000, 5'd26, f_wen);
    add_row(enc_j(21'h000008, 5'd27), nf, -1, '0, alu_add,
            32'h0000_0008, next_pc(), 32'h0000_0008, 5'd27, f_wen | f_jump);
    add_row(enc_r(7'h00, 5'd1, 5'd8, 3'd0, 5'd9), nf, 3, 32'h0BAD_F00D, alu_add, '0,
            32'h0BAD_F00D, preload_value(1), 5'd9, f_wen);
    add_row(enc_r(7'h00, 5'd0, 5'd8, 3'd0, 5'd28), nf, -1, '0, alu_add, '0,
            32'h0BAD_F00D, '0, 5'd28, f_wen);
  endtask

  task automatic check_output(input row_t r);
    check_word("out_dec.pc", out_dec.pc, r.pc);
    check_word("out_dec.inst", out_dec.inst, r.inst);
    check_alu("out_dec.alu_op", out_dec.alu_op, r.alu);
    check_word("out_dec.imm", out_dec.imm, r.imm);
    check_word("out_dec.op1", out_dec.op1, r.op1);
    check_word("out_dec.op2", out_dec.op2, r.op2);
    check_reg("out_dec.rd", out_dec.rd, r.rd);
    check_flag("out_dec.wen", out_dec.wen, r.flags[9]);
    check_flag("out_dec.load", out_dec.load, r.flags[8]);
    check_flag("out_dec.store", out_dec.store, r.flags[7]);
    check_flag("out_dec.jump", out_dec.jump, r.flags[6]);
    check_flag("out_dec.branch", out_dec.branch, r.flags[5]);
    check_flag("out_dec.ecall", out_dec.ecall, r.flags[4]);
    check_flag("out_dec.ebreak", out_dec.ebreak, r.flags[3]);
    check_flag("out_dec.mret", out_dec.mret, r.flags[2]);
    check_flag("out_dec.csr", out_dec.csr, r.flags[1]);
    check_flag("out_dec.illegal", out_dec.illegal, r.flags[0]);
  endtask

  // ------------------------------------------------------------
  // Accept one row, wait out any stall and check on handoff
  // ------------------------------------------------------------
  task automatic run_row(input int n, input row_t r);
    int  cycle;
    bit  done;
    @(negedge clock);
    in_valid = 1'b1;
    in_inst  = r.inst;
    in_pc    = r.pc;
    exu_fwd  = r.fwd;
    #1;
    check_flag("out_valid before accept", out_valid, 1'b0);
    check_flag("in_ready before accept", in_ready, 1'b1);
    @(posedge clock);
    cycle = 0;
    done  = 0;
    while (!done) begin
      @(negedge clock);
      in_valid  = 1'b0;
      wb        = (cycle == r.wb_at) ? r.rel : '0;
      out_ready = ($urandom % 4) != 0;
      #1;
      if (r.wb_at >= 0 && cycle <= r.wb_at && out_valid) begin
        $display("Row %0d left the stage before its writeback at cycle %0d", n, cycle);
        stop_run();
      end
      if (out_valid && out_ready) begin
        check_flag("in_ready on handoff", in_ready, 1'b1);
        check_output(r);
        done = 1;
      end else begin
        check_flag("in_ready while held", in_ready, 1'b0);
        if (cycle >= 40) begin
          $display("Row %0d produced no output within 40 cycles", n);
          stop_run();
        end
      end
      @(posedge clock);
      cycle++;
    end
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_inst     = '0;
    in_pc       = '0;
    out_ready   = 1'b0;
    exu_fwd     = '0;
    wb          = '0;
    table_ready = 1'b0;
    void'($urandom(32'h06faf5f2));
    build_table();
    table_ready = 1'b1;

    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_flag("out_valid after reset", out_valid, 1'b0);
    check_flag("in_ready after reset", in_ready, 1'b1);

    // Preload x1..x7 through writeback.
    for (int i = 1; i < 8; i++) begin
      @(negedge clock);
      wb.valid = 1'b1;
      wb.rd    = 5'(i);
      wb.data  = preload_value(i);
    end
    @(negedge clock);
    wb = '0;

    foreach (rows[i]) begin
      run_row(i, rows[i]);
    end
    @(negedge clock);
    #1;
    check_flag("out_valid after last row", out_valid, 1'b0);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog sized from the table length.
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (rows.size() * 40 + 100) * 20;
    #(limit_ns);
    $display("Watchdog expired after %0d ns without finishing the table", limit_ns);
    stop_run();
  end

endmodule

// ==== rv_decode.f ====
src/rv_decode_pkg.sv
src/rv_regfile.sv
src/rv_scoreboard.sv
src/rv_decoder.sv
src/rv_idu.sv
src/rv_decode_top.sv
dv/rv_decode_props.sv
dv/rv_decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode-stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f rv_decode.f \
  --top-module rv_decode_tb \
  -o rv_decode_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/rv_decode_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
